//--- include/autotest_params.svh
// autotest build parameters
`ifndef AUTOTEST_PARAMS_SVH
`define AUTOTEST_PARAMS_SVH

// operand and result widths in bytes
`define AT_OPA_BYTES 4
`define AT_OPB_BYTES 4
`define AT_RES_BYTES 4

// sd block geometry
`define AT_BLOCK_BYTES 512
`define AT_FIRST_BLOCK 32'h100000

// marks a block that carries a test vector
`define AT_SIGNATURE 32'hAABBCCDD

// execution limit, short for simulation
`define AT_TIMEOUT_CYCLES 1000

// cycle count field in the report
`define AT_CYCLE_BYTES 8

`endif

//--- hw/autotest_pkg.sv
// autotest shared types
`default_nettype none
`include "autotest_params.svh"

package autotest_pkg;

  // block field offsets
  localparam int unsigned SIG_BYTES = 4;
  localparam int unsigned OPA_OFS = SIG_BYTES;
  localparam int unsigned OPB_OFS = OPA_OFS + `AT_OPA_BYTES;
  localparam int unsigned EXP_OFS = OPB_OFS + `AT_OPB_BYTES;
  localparam int unsigned OBS_OFS = EXP_OFS + `AT_RES_BYTES;
  localparam int unsigned CYC_OFS = OBS_OFS + `AT_RES_BYTES;
  localparam int unsigned PAD_OFS = CYC_OFS + `AT_CYCLE_BYTES;

  typedef logic [9:0] byte_idx_t;
  typedef logic [8*`AT_OPA_BYTES-1:0] opa_t;
  typedef logic [8*`AT_OPB_BYTES-1:0] opb_t;
  typedef logic [8*`AT_RES_BYTES-1:0] res_t;
  typedef logic [8*`AT_CYCLE_BYTES-1:0] cycles_t;
  typedef logic [31:0] blk_addr_t;

  typedef enum logic [2:0] {
    FLD_SIG,
    FLD_OPA,
    FLD_OPB,
    FLD_EXP,
    FLD_OBS,
    FLD_CYC,
    FLD_PAD
  } field_t;

  typedef enum logic [3:0] {
    ST_IDLE,
    ST_RST_HOST,
    ST_WAIT_BLOCK,
    ST_READ_BYTE,
    ST_WAIT_BYTE,
    ST_CHECK_SIG,
    ST_RUN,
    ST_COMPARE,
    ST_OPEN_WRITE,
    ST_WRITE_BYTE,
    ST_WAIT_WR_BYTE,
    ST_NEXT_BLOCK,
    ST_HALT
  } seq_state_t;

  // which field a block position falls in
  function automatic field_t field_of(byte_idx_t idx);
    if (idx < OPA_OFS) return FLD_SIG;
    if (idx < OPB_OFS) return FLD_OPA;
    if (idx < EXP_OFS) return FLD_OPB;
    if (idx < OBS_OFS) return FLD_EXP;
    if (idx < CYC_OFS) return FLD_OBS;
    if (idx < PAD_OFS) return FLD_CYC;
    return FLD_PAD;
  endfunction

  // first block position of a field
  function automatic byte_idx_t field_base(field_t fld);
    case (fld)
      FLD_SIG: return byte_idx_t'(0);
      FLD_OPA: return byte_idx_t'(OPA_OFS);
      FLD_OPB: return byte_idx_t'(OPB_OFS);
      FLD_EXP: return byte_idx_t'(EXP_OFS);
      FLD_OBS: return byte_idx_t'(OBS_OFS);
      FLD_CYC: return byte_idx_t'(CYC_OFS);
      default: return byte_idx_t'(PAD_OFS);
    endcase
  endfunction

endpackage

`default_nettype wire

//--- hw/vector_loader.sv
// test vector decode stage
`default_nettype none
`include "autotest_params.svh"

module vector_loader (
  input  wire logic                 clk,
  input  wire logic                 rst,
  input  wire logic                 clear_i,
  input  wire logic                 byte_valid_i,
  input  wire autotest_pkg::byte_idx_t byte_idx_i,
  input  wire logic [7:0]           byte_i,
  output logic                      sig_ok_o,
  output autotest_pkg::opa_t        operand_a_o,
  output autotest_pkg::opb_t        operand_b_o,
  output autotest_pkg::res_t        expected_o
);

  import autotest_pkg::*;

  logic [8*SIG_BYTES-1:0] sig_q;
  opa_t opa_q;
  opb_t opb_q;
  res_t exp_q;

  field_t fld;
  byte_idx_t lane;

  always_comb begin
    fld = field_of(byte_idx_i);
    lane = byte_idx_i - field_base(fld);
  end

  always_ff @(posedge clk) begin
    if (rst || clear_i) begin
      sig_q <= '0;
      opa_q <= '0;
      opb_q <= '0;
      exp_q <= '0;
    end else if (byte_valid_i) begin
      case (fld)
        // signature arrives msb first
        FLD_SIG: sig_q[8*(SIG_BYTES-1-lane) +: 8] <= byte_i;
        FLD_OPA: opa_q[8*lane +: 8] <= byte_i;
        FLD_OPB: opb_q[8*lane +: 8] <= byte_i;
        FLD_EXP: exp_q[8*lane +: 8] <= byte_i;
        // rest of the block carries nothing for us
        default: ;
      endcase
    end
  end

  assign sig_ok_o = (sig_q == `AT_SIGNATURE);
  assign operand_a_o = opa_q;
  assign operand_b_o = opb_q;
  assign expected_o = exp_q;

  // byte counter of the sequencer stays inside the block
  a_idx_in_block: assert property (
    @(posedge clk) disable iff (rst)
    byte_valid_i |-> (byte_idx_i < `AT_BLOCK_BYTES)
  ) else $error("byte strobe outside block, index %0d", byte_idx_i);

endmodule

`default_nettype wire

//--- hw/test_runner.sv
// uut execute stage
`default_nettype none
`include "autotest_params.svh"

module test_runner (
  input  wire logic               clk,
  input  wire logic               rst,
  input  wire logic               launch_i,
  input  wire logic               end_uut_i,
  input  wire logic               err_uut_i,
  input  wire autotest_pkg::res_t result_uut_i,
  output logic                    rst_uut_o,
  output logic                    done_o,
  output logic                    failed_o,
  output autotest_pkg::res_t      observed_o,
  output autotest_pkg::cycles_t   cycles_o
);

  import autotest_pkg::*;

  logic running_q;
  logic done_q;
  logic failed_q;
  res_t observed_q;
  cycles_t cycles_q;
  logic timeout;

  assign timeout = (cycles_q == cycles_t'(`AT_TIMEOUT_CYCLES - 1));

  always_ff @(posedge clk) begin
    done_q <= 1'b0;
    if (rst) begin
      running_q <= 1'b0;
      failed_q <= 1'b0;
      cycles_q <= '0;
    end else if (launch_i) begin
      running_q <= 1'b1;
      failed_q <= 1'b0;
      cycles_q <= '0;
    end else if (running_q) begin
      cycles_q <= cycles_q + 1'b1;
      if (end_uut_i || err_uut_i || timeout) begin
        running_q <= 1'b0;
        done_q <= 1'b1;
        // no end flag here means error or timeout
        failed_q <= err_uut_i || !end_uut_i;
      end
    end
  end

  // result taken on the done edge
  always_ff @(posedge clk) begin
    if (running_q && (end_uut_i || err_uut_i || timeout)) begin
      observed_q <= result_uut_i;
    end
  end

  assign rst_uut_o = !running_q;
  assign done_o = done_q;
  assign failed_o = failed_q;
  assign observed_o = observed_q;
  assign cycles_o = cycles_q;

  a_done_after_launch: assert property (
    @(posedge clk) disable iff (rst)
    done_o |-> $past(running_q)
  ) else $error("done without a launched test");

  // sequencer keeps one test in flight
  a_no_relaunch: assert property (
    @(posedge clk) disable iff (rst)
    launch_i |-> !running_q
  ) else $error("launch while a test is running");

endmodule

`default_nettype wire

//--- hw/result_writer.sv
// result compare and report stage
`default_nettype none
`include "autotest_params.svh"

module result_writer (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    clear_count_i,
  input  wire logic                    judge_i,
  input  wire autotest_pkg::byte_idx_t byte_idx_i,
  input  wire autotest_pkg::opa_t      operand_a_i,
  input  wire autotest_pkg::opb_t      operand_b_i,
  input  wire autotest_pkg::res_t      expected_i,
  input  wire autotest_pkg::res_t      observed_i,
  input  wire autotest_pkg::cycles_t   cycles_i,
  input  wire logic                    failed_i,
  output logic [7:0]                   report_byte_o,
  output logic [31:0]                  error_count_o
);

  import autotest_pkg::*;

  // only valid blocks get a report
  localparam logic [8*SIG_BYTES-1:0] SIG_WORD = `AT_SIGNATURE;

  logic [31:0] err_cnt_q;
  logic mismatch;
  field_t fld;
  byte_idx_t lane;

  assign mismatch = failed_i || (observed_i != expected_i);

  always_ff @(posedge clk) begin
    if (rst || clear_count_i) begin
      err_cnt_q <= '0;
    end else if (judge_i && mismatch) begin
      err_cnt_q <= err_cnt_q + 1'b1;
    end
  end

  assign error_count_o = err_cnt_q;

  // report byte straight from the index
  always_comb begin
    fld = field_of(byte_idx_i);
    lane = byte_idx_i - field_base(fld);
    case (fld)
      FLD_SIG: report_byte_o = SIG_WORD[8*(SIG_BYTES-1-lane) +: 8];
      FLD_OPA: report_byte_o = operand_a_i[8*lane +: 8];
      FLD_OPB: report_byte_o = operand_b_i[8*lane +: 8];
      FLD_EXP: report_byte_o = expected_i[8*lane +: 8];
      FLD_OBS: report_byte_o = observed_i[8*lane +: 8];
      FLD_CYC: report_byte_o = cycles_i[8*lane +: 8];
      // padding to the end of the block
      default: report_byte_o = 8'hFF;
    endcase
  end

endmodule

`default_nettype wire

//--- hw/autotest_ctrl.sv
// self-test sequencer top
`default_nettype none
`include "autotest_params.svh"

module autotest_ctrl (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    start_i,
  output logic                         run_busy_o,
  output logic [31:0]                  error_count_o,
  // sd host
  output logic                         sd_rst_o,
  output logic                         sd_rd_block_o,
  output logic                         sd_rd_byte_o,
  output logic                         sd_wr_block_o,
  output logic                         sd_wr_byte_o,
  output autotest_pkg::blk_addr_t      sd_addr_o,
  output logic [7:0]                   sd_wdata_o,
  input  wire logic                    sd_busy_i,
  input  wire logic [7:0]              sd_rdata_i,
  // uut
  output logic                         rst_uut_o,
  output autotest_pkg::opa_t           operand_a_o,
  output autotest_pkg::opb_t           operand_b_o,
  input  wire logic                    end_uut_i,
  input  wire logic                    err_uut_i,
  input  wire autotest_pkg::res_t      result_uut_i
);

  import autotest_pkg::*;

  seq_state_t state_q, state_d;
  byte_idx_t byte_cnt_q;
  blk_addr_t addr_q;
  logic [7:0] wdata_q;
  logic seen_q;

  logic byte_valid, launch, judge, done, failed, sig_ok;
  logic cnt_clr, cnt_inc, wdata_ld, addr_inc, run_start;
  logic [7:0] report_byte;
  res_t expected, observed;
  cycles_t cycles;

  assign run_start = (state_q == ST_IDLE) && start_i;

  always_comb begin
    state_d = state_q;
    {sd_rst_o, sd_rd_block_o, sd_rd_byte_o, sd_wr_block_o, sd_wr_byte_o} = '0;
    {byte_valid, launch, judge, cnt_clr, cnt_inc, wdata_ld, addr_inc} = '0;
    case (state_q)
      ST_IDLE: if (start_i) state_d = ST_RST_HOST;
      ST_RST_HOST: begin
        sd_rst_o = !seen_q;
        if (seen_q && !sd_busy_i) begin
          cnt_clr = 1'b1;
          state_d = ST_WAIT_BLOCK;
        end
      end
      ST_WAIT_BLOCK: begin
        sd_rd_block_o = 1'b1;
        if (seen_q && !sd_busy_i) state_d = ST_READ_BYTE;
      end
      ST_READ_BYTE: begin
        sd_rd_block_o = 1'b1;
        sd_rd_byte_o = 1'b1;
        if (sd_busy_i) state_d = ST_WAIT_BYTE;
      end
      ST_WAIT_BYTE: begin
        sd_rd_block_o = 1'b1;
        if (!sd_busy_i) begin
          // rdata valid from the busy fall
          byte_valid = 1'b1;
          cnt_inc = 1'b1;
          if (byte_cnt_q == byte_idx_t'(`AT_BLOCK_BYTES - 1)) state_d = ST_CHECK_SIG;
          else state_d = ST_READ_BYTE;
        end
      end
      ST_CHECK_SIG: begin
        launch = sig_ok;
        state_d = sig_ok ? ST_RUN : ST_HALT;
      end
      ST_RUN: if (done) state_d = ST_COMPARE;
      ST_COMPARE: begin
        judge = 1'b1;
        cnt_clr = 1'b1;
        state_d = ST_OPEN_WRITE;
      end
      ST_OPEN_WRITE: begin
        sd_wr_block_o = 1'b1;
        if (seen_q && !sd_busy_i) begin
          wdata_ld = 1'b1;
          state_d = ST_WRITE_BYTE;
        end
      end
      ST_WRITE_BYTE: begin
        sd_wr_block_o = 1'b1;
        sd_wr_byte_o = 1'b1;
        if (sd_busy_i) begin
          cnt_inc = 1'b1;
          state_d = ST_WAIT_WR_BYTE;
        end
      end
      ST_WAIT_WR_BYTE: begin
        sd_wr_block_o = 1'b1;
        if (!sd_busy_i) begin
          // counter already points past the byte just sent
          if (byte_cnt_q == byte_idx_t'(`AT_BLOCK_BYTES)) begin
            state_d = ST_NEXT_BLOCK;
          end else begin
            wdata_ld = 1'b1;
            state_d = ST_WRITE_BYTE;
          end
        end
      end
      ST_NEXT_BLOCK: begin
        if (!sd_busy_i) begin
          cnt_clr = 1'b1;
          addr_inc = 1'b1;
          state_d = ST_WAIT_BLOCK;
        end
      end
      ST_HALT: state_d = ST_IDLE;
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      seen_q <= 1'b0;
      byte_cnt_q <= '0;
      addr_q <= blk_addr_t'(`AT_FIRST_BLOCK);
    end else begin
      state_q <= state_d;
      // busy seen since entering the current state
      seen_q <= (state_d == state_q) && (seen_q || sd_busy_i);
      if (cnt_clr) byte_cnt_q <= '0;
      else if (cnt_inc) byte_cnt_q <= byte_cnt_q + 1'b1;
      if (run_start) addr_q <= blk_addr_t'(`AT_FIRST_BLOCK);
      else if (addr_inc) addr_q <= addr_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wdata_ld) wdata_q <= report_byte;
  end

  assign run_busy_o = (state_q != ST_IDLE);
  assign sd_addr_o = addr_q;
  assign sd_wdata_o = wdata_q;

  vector_loader u_loader (
    .clk          (clk),
    .rst          (rst),
    .clear_i      ((state_q == ST_IDLE) || (state_q == ST_NEXT_BLOCK)),
    .byte_valid_i (byte_valid),
    .byte_idx_i   (byte_cnt_q),
    .byte_i       (sd_rdata_i),
    .sig_ok_o     (sig_ok),
    .operand_a_o  (operand_a_o),
    .operand_b_o  (operand_b_o),
    .expected_o   (expected)
  );

  test_runner u_runner (
    .clk          (clk),
    .rst          (rst),
    .launch_i     (launch),
    .end_uut_i    (end_uut_i),
    .err_uut_i    (err_uut_i),
    .result_uut_i (result_uut_i),
    .rst_uut_o    (rst_uut_o),
    .done_o       (done),
    .failed_o     (failed),
    .observed_o   (observed),
    .cycles_o     (cycles)
  );

  result_writer u_writer (
    .clk           (clk),
    .rst           (rst),
    .clear_count_i (run_start),
    .judge_i       (judge),
    .byte_idx_i    (byte_cnt_q),
    .operand_a_i   (operand_a_o),
    .operand_b_i   (operand_b_o),
    .expected_i    (expected),
    .observed_i    (observed),
    .cycles_i      (cycles),
    .failed_i      (failed),
    .report_byte_o (report_byte),
    .error_count_o (error_count_o)
  );

  a_rd_wr_exclusive: assert property (
    @(posedge clk) disable iff (rst)
    !(sd_rd_block_o && sd_wr_block_o)
  ) else $error("read and write block commands both high");

  // host samples write data any time during the byte command
  a_wdata_stable: assert property (
    @(posedge clk) disable iff (rst)
    sd_wr_byte_o && $past(sd_wr_byte_o) |-> $stable(sd_wdata_o)
  ) else $error("write data changed during byte command");

endmodule

`default_nettype wire

//--- tests/sd_card_model.sv
// behavioral sd host and adder uut
`default_nettype none
`include "autotest_params.svh"

module sd_card_model (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    sd_rst_i,
  input  wire logic                    rd_block_i,
  input  wire logic                    rd_byte_i,
  input  wire logic                    wr_block_i,
  input  wire logic                    wr_byte_i,
  input  wire autotest_pkg::blk_addr_t addr_i,
  input  wire logic [7:0]              wdata_i,
  output logic                         busy_o,
  output logic [7:0]                   rdata_o
);

  import autotest_pkg::*;

  // small window of backed blocks from the first block up
  localparam int unsigned WIN_BLOCKS = 8;
  localparam int unsigned WIN_BYTES = WIN_BLOCKS * `AT_BLOCK_BYTES;

  logic [7:0] mem [WIN_BYTES];
  int unsigned wr_bytes [WIN_BLOCKS];
  int unsigned stray;
  logic [7:0] delay_tab [64];
  int unsigned op_cnt;
  int unsigned wait_cnt;
  logic rd_open;
  logic wr_open;
  blk_addr_t cur_blk;
  int unsigned cur_idx;
  logic [7:0] pend;

  function automatic logic [7:0] fill_byte(blk_addr_t blk, int unsigned idx);
    logic [47:0] a;
    a = {7'd0, blk, idx[8:0]};
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ a[39:32] ^ a[47:40] ^ 8'h5A;
  endfunction

  function automatic logic in_window(blk_addr_t blk);
    return (blk >= blk_addr_t'(`AT_FIRST_BLOCK)) &&
           (blk < blk_addr_t'(`AT_FIRST_BLOCK + WIN_BLOCKS));
  endfunction

  function automatic int unsigned slot(blk_addr_t blk);
    return blk - blk_addr_t'(`AT_FIRST_BLOCK);
  endfunction

  function automatic logic [7:0] get_byte(blk_addr_t blk, int unsigned idx);
    if (in_window(blk)) return mem[slot(blk) * `AT_BLOCK_BYTES + idx];
    return fill_byte(blk, idx);
  endfunction

  task automatic put_byte(blk_addr_t blk, int unsigned idx, logic [7:0] val);
    if (in_window(blk)) mem[slot(blk) * `AT_BLOCK_BYTES + idx] = val;
  endtask

  function automatic int unsigned bytes_written(blk_addr_t blk);
    if (in_window(blk)) return wr_bytes[slot(blk)];
    return 0;
  endfunction

  function automatic int unsigned stray_count();
    return stray;
  endfunction

  task automatic clear_marks();
    int unsigned i;
    for (i = 0; i < WIN_BLOCKS; i++) wr_bytes[i] = 0;
    stray = 0;
  endtask

  task automatic set_delay(int unsigned i, logic [7:0] d);
    delay_tab[i % 64] = d;
  endtask

  // busy stays high for one cycle plus the table delay
  task automatic start_op();
    busy_o = 1'b1;
    wait_cnt = delay_tab[op_cnt % 64];
    op_cnt = op_cnt + 1;
  endtask

  initial begin
    int unsigned i;
    busy_o = 1'b0;
    rdata_o = 8'h00;
    op_cnt = 0;
    wait_cnt = 0;
    rd_open = 1'b0;
    wr_open = 1'b0;
    stray = 0;
    for (i = 0; i < WIN_BYTES; i++) begin
      mem[i] = fill_byte(blk_addr_t'(`AT_FIRST_BLOCK + i / `AT_BLOCK_BYTES),
                         i % `AT_BLOCK_BYTES);
    end
    for (i = 0; i < WIN_BLOCKS; i++) wr_bytes[i] = 0;
  end

  always @(negedge clk) begin
    if (rst) begin
      busy_o = 1'b0;
      rd_open = 1'b0;
      wr_open = 1'b0;
    end else if (busy_o) begin
      if (wait_cnt == 0) begin
        busy_o = 1'b0;
        rdata_o = pend;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end else begin
      // a block ends when its command level drops
      if (!rd_block_i) rd_open = 1'b0;
      if (!wr_block_i) wr_open = 1'b0;
      if (sd_rst_i) begin
        rd_open = 1'b0;
        wr_open = 1'b0;
        start_op();
      end else if (rd_block_i && !rd_open) begin
        rd_open = 1'b1;
        cur_blk = addr_i;
        cur_idx = 0;
        start_op();
      end else if (rd_open && rd_byte_i) begin
        pend = get_byte(cur_blk, cur_idx);
        cur_idx = cur_idx + 1;
        start_op();
      end else if (wr_block_i && !wr_open) begin
        wr_open = 1'b1;
        cur_blk = addr_i;
        cur_idx = 0;
        start_op();
      end else if (wr_open && wr_byte_i) begin
        if (in_window(cur_blk) && cur_idx < `AT_BLOCK_BYTES) begin
          put_byte(cur_blk, cur_idx, wdata_i);
          wr_bytes[slot(cur_blk)] = wr_bytes[slot(cur_blk)] + 1;
        end else begin
          stray = stray + 1;
        end
        cur_idx = cur_idx + 1;
        start_op();
      end
    end
  end

endmodule

module adder_model (
  input  wire logic               clk,
  input  wire logic               rst_uut_i,
  input  wire autotest_pkg::opa_t operand_a_i,
  input  wire autotest_pkg::opb_t operand_b_i,
  input  wire logic [7:0]         delay_i,
  input  wire logic               err_mode_i,
  input  wire logic               hang_i,
  output logic                    end_o,
  output logic                    err_o,
  output autotest_pkg::res_t      result_o
);

  import autotest_pkg::*;

  int unsigned cnt;

  initial begin
    cnt = 0;
    end_o = 1'b0;
    err_o = 1'b0;
    result_o = '0;
  end

  always @(negedge clk) begin
    if (rst_uut_i) begin
      cnt = 0;
      end_o = 1'b0;
      err_o = 1'b0;
    end else if (!hang_i && !end_o && !err_o) begin
      if (cnt >= delay_i) begin
        result_o = res_t'(operand_a_i + operand_b_i);
        if (err_mode_i) err_o = 1'b1;
        else end_o = 1'b1;
      end else begin
        cnt = cnt + 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_autotest.sv
// self-test sequencer testbench
`default_nettype none
`include "autotest_params.svh"

module tb_autotest;

  import autotest_pkg::*;

  localparam int unsigned RUN_LIMIT = 100000;
  localparam int unsigned START_LIMIT = 16;
  localparam logic [31:0] BAD_SIG = `AT_SIGNATURE ^ 32'h0000_0100;
  localparam blk_addr_t FIRST = blk_addr_t'(`AT_FIRST_BLOCK);

  logic clk;
  logic rst;
  logic start;
  logic run_busy;
  logic [31:0] error_count;
  logic sd_rst;
  logic sd_rd_block;
  logic sd_rd_byte;
  logic sd_wr_block;
  logic sd_wr_byte;
  blk_addr_t sd_addr;
  logic [7:0] sd_wdata;
  logic sd_busy;
  logic [7:0] sd_rdata;
  logic rst_uut;
  opa_t operand_a;
  opb_t operand_b;
  logic end_uut;
  logic err_uut;
  res_t result_uut;

  logic [7:0] uut_delay;
  logic uut_err;
  logic uut_hang;

  int unsigned mismatch_cnt;
  int unsigned fail_cnt;
  logic aborted;

  autotest_ctrl uut (
    .clk           (clk),
    .rst           (rst),
    .start_i       (start),
    .run_busy_o    (run_busy),
    .error_count_o (error_count),
    .sd_rst_o      (sd_rst),
    .sd_rd_block_o (sd_rd_block),
    .sd_rd_byte_o  (sd_rd_byte),
    .sd_wr_block_o (sd_wr_block),
    .sd_wr_byte_o  (sd_wr_byte),
    .sd_addr_o     (sd_addr),
    .sd_wdata_o    (sd_wdata),
    .sd_busy_i     (sd_busy),
    .sd_rdata_i    (sd_rdata),
    .rst_uut_o     (rst_uut),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .end_uut_i     (end_uut),
    .err_uut_i     (err_uut),
    .result_uut_i  (result_uut)
  );

  sd_card_model card (
    .clk        (clk),
    .rst        (rst),
    .sd_rst_i   (sd_rst),
    .rd_block_i (sd_rd_block),
    .rd_byte_i  (sd_rd_byte),
    .wr_block_i (sd_wr_block),
    .wr_byte_i  (sd_wr_byte),
    .addr_i     (sd_addr),
    .wdata_i    (sd_wdata),
    .busy_o     (sd_busy),
    .rdata_o    (sd_rdata)
  );

  adder_model adder (
    .clk         (clk),
    .rst_uut_i   (rst_uut),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .delay_i     (uut_delay),
    .err_mode_i  (uut_err),
    .hang_i      (uut_hang),
    .end_o       (end_uut),
    .err_o       (err_uut),
    .result_o    (result_uut)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_opa(input string name, input opa_t got, input opa_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_opb(input string name, input opb_t got, input opb_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_res(input string name, input res_t got, input res_t exp);
    if (got !== exp) begin
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
      mismatch_cnt++;
    end
  endtask

  task automatic check_cycles(input string name, input cycles_t got,
                              input cycles_t lo, input cycles_t hi);
    if ($isunknown(got) || got < lo || got > hi) begin
      $display("ERR %0t %s got %0d expected %0d to %0d", $time, name, got, lo, hi);
      mismatch_cnt++;
    end
  endtask

  // little endian field of a card block
  function automatic logic [63:0] field_le(blk_addr_t blk, int unsigned ofs, int unsigned n);
    logic [63:0] v;
    int unsigned i;
    v = '0;
    for (i = 0; i < n; i++) v[8*i +: 8] = card.get_byte(blk, ofs + i);
    return v;
  endfunction

  task automatic preload_block(input blk_addr_t blk, input logic [31:0] sig,
                               input opa_t a, input opb_t b, input res_t e);
    int unsigned i;
    // signature goes msb first, the rest lsb first
    for (i = 0; i < SIG_BYTES; i++) card.put_byte(blk, i, sig[8*(SIG_BYTES-1-i) +: 8]);
    for (i = 0; i < `AT_OPA_BYTES; i++) card.put_byte(blk, OPA_OFS + i, a[8*i +: 8]);
    for (i = 0; i < `AT_OPB_BYTES; i++) card.put_byte(blk, OPB_OFS + i, b[8*i +: 8]);
    for (i = 0; i < `AT_RES_BYTES; i++) card.put_byte(blk, EXP_OFS + i, e[8*i +: 8]);
  endtask

  task automatic check_report(input blk_addr_t blk, input opa_t a, input opb_t b,
                              input res_t e, input logic check_obs, input logic hang);
    logic [31:0] sig;
    int unsigned i;
    sig = {card.get_byte(blk, 0), card.get_byte(blk, 1),
           card.get_byte(blk, 2), card.get_byte(blk, 3)};
    check_count("report signature", sig, `AT_SIGNATURE);
    check_opa("report operand A", opa_t'(field_le(blk, OPA_OFS, `AT_OPA_BYTES)), a);
    check_opb("report operand B", opb_t'(field_le(blk, OPB_OFS, `AT_OPB_BYTES)), b);
    check_res("report expected", res_t'(field_le(blk, EXP_OFS, `AT_RES_BYTES)), e);
    if (check_obs) begin
      check_res("report observed", res_t'(field_le(blk, OBS_OFS, `AT_RES_BYTES)),
                res_t'(a + b));
    end
    if (hang) begin
      check_cycles("report cycles", cycles_t'(field_le(blk, CYC_OFS, `AT_CYCLE_BYTES)),
                   cycles_t'(`AT_TIMEOUT_CYCLES), '1);
    end else begin
      check_cycles("report cycles", cycles_t'(field_le(blk, CYC_OFS, `AT_CYCLE_BYTES)),
                   cycles_t'(1), cycles_t'(`AT_TIMEOUT_CYCLES - 1));
    end
    for (i = PAD_OFS; i < `AT_BLOCK_BYTES; i++) begin
      check_byte($sformatf("report byte %0d", i), card.get_byte(blk, i), 8'hFF);
    end
    check_count("report bytes written", card.bytes_written(blk), `AT_BLOCK_BYTES);
  endtask

  // one start pulse, then wait for the whole run to end
  task automatic run_sequence();
    int unsigned n;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    n = 0;
    while (!run_busy && n < START_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (!run_busy) begin
      $display("run did not start within %0d cycles", START_LIMIT);
      fail_cnt++;
      aborted = 1'b1;
    end else begin
      n = 0;
      while (run_busy && n < RUN_LIMIT) begin
        @(negedge clk);
        n++;
      end
      if (run_busy) begin
        $display("run did not finish within %0d cycles", RUN_LIMIT);
        fail_cnt++;
        aborted = 1'b1;
      end
    end
  endtask

  task automatic run_single(input opa_t a, input opb_t b, input res_t e,
                            input logic err_mode, input logic hang,
                            input logic [31:0] exp_errors);
    card.clear_marks();
    preload_block(FIRST, `AT_SIGNATURE, a, b, e);
    preload_block(FIRST + 1, BAD_SIG, '0, '0, '0);
    uut_delay = 1 + ($urandom % 40);
    uut_err = err_mode;
    uut_hang = hang;
    run_sequence();
    if (!aborted) begin
      check_count("error_count_o", error_count, exp_errors);
      check_report(FIRST, a, b, e, !hang, hang);
      check_count("bytes written at bad block", card.bytes_written(FIRST + 1), 0);
    end
  endtask

  task automatic check_reset_state();
    check_bit("run_busy_o", run_busy, 1'b0);
    check_count("error_count_o", error_count, 0);
    check_bit("sd_rst_o", sd_rst, 1'b0);
    check_bit("sd_rd_block_o", sd_rd_block, 1'b0);
    check_bit("sd_rd_byte_o", sd_rd_byte, 1'b0);
    check_bit("sd_wr_block_o", sd_wr_block, 1'b0);
    check_bit("sd_wr_byte_o", sd_wr_byte, 1'b0);
    check_bit("rst_uut_o", rst_uut, 1'b1);
  endtask

  task automatic test_good_sum();
    opa_t a;
    opb_t b;
    a = $urandom;
    b = $urandom;
    run_single(a, b, res_t'(a + b), 1'b0, 1'b0, 0);
  endtask

  task automatic test_wrong_expected();
    opa_t a;
    opb_t b;
    a = $urandom;
    b = $urandom;
    run_single(a, b, ~res_t'(a + b), 1'b0, 1'b0, 1);
  endtask

  task automatic test_uut_error();
    opa_t a;
    opb_t b;
    a = $urandom;
    b = $urandom;
    run_single(a, b, res_t'(a + b), 1'b1, 1'b0, 1);
  endtask

  task automatic test_uut_hang();
    opa_t a;
    opb_t b;
    res_t stale;
    a = $urandom;
    b = $urandom;
    // a hanging uut keeps its last result, so only the timeout can count
    stale = result_uut;
    run_single(a, b, stale, 1'b0, 1'b1, 1);
  endtask

  task automatic test_multi_block();
    opa_t a [3];
    opb_t b [3];
    int unsigned k;
    card.clear_marks();
    for (k = 0; k < 3; k++) begin
      a[k] = $urandom;
      b[k] = $urandom;
      preload_block(FIRST + k, `AT_SIGNATURE, a[k], b[k], res_t'(a[k] + b[k]));
    end
    preload_block(FIRST + 3, BAD_SIG, '0, '0, '0);
    uut_delay = 1 + ($urandom % 40);
    uut_err = 1'b0;
    uut_hang = 1'b0;
    run_sequence();
    if (!aborted) begin
      check_count("error_count_o", error_count, 0);
      for (k = 0; k < 3; k++) check_report(FIRST + k, a[k], b[k], res_t'(a[k] + b[k]),
                                           1'b1, 1'b0);
      check_count("bytes written at fourth block", card.bytes_written(FIRST + 3), 0);
      check_count("writes outside the card window", card.stray_count(), 0);
    end
  endtask

  initial begin
    int unsigned i;
    void'($urandom(32'h7c07c0f1));
    rst = 1'b1;
    start = 1'b0;
    uut_delay = 8'd1;
    uut_err = 1'b0;
    uut_hang = 1'b0;
    mismatch_cnt = 0;
    fail_cnt = 0;
    aborted = 1'b0;
    for (i = 0; i < 64; i++) card.set_delay(i, $urandom % 4);
    repeat (10) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_reset_state();
    test_good_sum();
    if (!aborted) test_wrong_expected();
    if (!aborted) test_uut_error();
    if (!aborted) test_uut_hang();
    if (!aborted) test_multi_block();
    $display("summary: %0d value errors, %0d other failures", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
hw/autotest_pkg.sv
hw/vector_loader.sv
hw/test_runner.sv
hw/result_writer.sv
hw/autotest_ctrl.sv
tests/sd_card_model.sv
tests/tb_autotest.sv

//--- Bender.yml
package:
  name: autotest

sources:
  - include_dirs:
      - include
    files:
      - hw/autotest_pkg.sv
      - hw/vector_loader.sv
      - hw/test_runner.sv
      - hw/result_writer.sv
      - hw/autotest_ctrl.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/sd_card_model.sv
      - tests/tb_autotest.sv
